// File: flist.f
+incdir+hw
+incdir+verif
hw/lease_cache_pkg.sv
hw/cache_event_if.sv
hw/lease_tag_store.sv
hw/cache_performance_controller.sv
hw/lease_cache_top.sv
verif/lease_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lease cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f \
	--top-module lease_cache_tb \
	--Mdir obj_dir \
	-o lease_cache_sim

./obj_dir/lease_cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
exit 0

// File: verif/lease_cache_model.svh
`ifndef LEASE_CACHE_MODEL_SVH
`define LEASE_CACHE_MODEL_SVH

localparam int TAG_W		= 32 - `LEASE_CACHE_INDEX_W - `LEASE_CACHE_OFFSET_W;
localparam int EV_HIT		= 0;
localparam int EV_MISS		= 1;
localparam int EV_WB		= 2;
localparam int EV_EXPIRED	= 3;
localparam int EV_MULTI		= 4;
localparam int EV_DEFAULTED	= 5;
localparam int EV_WALL		= 6;		// enabled cycles, no pulse behind it

// random source
// ----------------------------------------
logic [31:0]	lfsr_state = 32'h70bf_66a8;

// galois form, taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < n; i++) begin
		value = {value[30:0], lfsr_state[0]};		// one step per bit
		lfsr_state = lfsr_next(lfsr_state);
	end
	return value;
endfunction

// reference cache and counters
// ----------------------------------------
logic					m_valid	[`LEASE_CACHE_LINES];
logic					m_dirty	[`LEASE_CACHE_LINES];
logic [TAG_W-1:0]		m_tag	[`LEASE_CACHE_LINES];
logic [`LEASE_W-1:0]	m_lease	[`LEASE_CACHE_LINES];
logic [63:0]			m_count	[7];
logic [5:0]				m_pending;		// pulses of the access at the last edge

function automatic void model_reset();
	for (int i = 0; i < `LEASE_CACHE_LINES; i++) begin
		m_valid[i] = 1'b0;
		m_dirty[i] = 1'b0;
		m_lease[i] = '0;
	end
	for (int e = 0; e < 7; e++)
		m_count[e] = '0;
	m_pending = '0;
endfunction

// one access against pre-access state, returns its six pulses
function automatic logic [5:0] model_access(input logic [31:0] addr, input logic is_write,
		input logic [`LEASE_W-1:0] lease);
	int						idx;
	logic [TAG_W-1:0]		tag;
	logic [`LEASE_W-1:0]	renew;
	logic					others_zero;
	logic [5:0]				ev;
	idx = int'((addr >> `LEASE_CACHE_OFFSET_W) % `LEASE_CACHE_LINES);
	tag = TAG_W'(addr >> (`LEASE_CACHE_OFFSET_W + `LEASE_CACHE_INDEX_W));
	renew = (lease == 0) ? `LEASE_W'(`LEASE_DEFAULT) : lease;
	ev = '0;
	ev[EV_DEFAULTED] = (lease == 0);
	if (m_valid[idx] && m_tag[idx] == tag) begin
		ev[EV_HIT] = 1'b1;
		if (is_write)
			m_dirty[idx] = 1'b1;
	end else begin
		ev[EV_MISS] = 1'b1;
		ev[EV_WB] = m_valid[idx] && m_dirty[idx];
		ev[EV_EXPIRED] = m_valid[idx] && (m_lease[idx] == 0);
		others_zero = 1'b0;
		for (int j = 0; j < `LEASE_CACHE_LINES; j++)
			if (j != idx && m_valid[j] && m_lease[j] == 0)
				others_zero = 1'b1;
		ev[EV_MULTI] = ev[EV_EXPIRED] && others_zero;
		m_tag[idx] = tag;
		m_dirty[idx] = is_write;		// fresh fill
	end
	for (int j = 0; j < `LEASE_CACHE_LINES; j++)
		if (j != idx && m_valid[j] && m_lease[j] != 0)
			m_lease[j] = m_lease[j] - 1;		// others age, floor at zero
	m_valid[idx] = 1'b1;
	m_lease[idx] = renew;
	return ev;
endfunction

// one rising edge: count last access pulses if enabled, then take the new access
function automatic void model_cycle(input logic req, input logic [31:0] addr,
		input logic is_write, input logic [`LEASE_W-1:0] lease, input logic en);
	if (en) begin
		for (int e = 0; e < 6; e++)
			if (m_pending[e])
				m_count[e] = m_count[e] + 64'd1;
		m_count[EV_WALL] = m_count[EV_WALL] + 64'd1;
	end
	m_pending = req ? model_access(addr, is_write, lease) : 6'b0;
endfunction

// expected comm_o for a configuration word
function automatic logic [31:0] model_readback(input logic [31:0] comm);
	logic [63:0] cnt;
	if (comm[3:0] == 4'd15)
		return `CACHE_ID_STRUCTURE | `CACHE_ID_REPLACEMENT;
	case (comm[3:1])
		3'd0:		cnt = m_count[EV_HIT];
		3'd1:		cnt = m_count[EV_MISS];
		3'd2:		cnt = m_count[EV_WB];
		3'd3:		cnt = m_count[EV_WALL];
		3'd4:		cnt = m_count[EV_EXPIRED];
		3'd5:		cnt = m_count[EV_DEFAULTED];
		3'd6:		cnt = m_count[EV_MULTI];
		default:	cnt = '0;		// select 14
	endcase
	return comm[0] ? cnt[63:32] : cnt[31:0];
endfunction

`endif

// File: verif/lease_cache_tb.sv
`timescale 1ns/1ps

`include "lease_cache_config.svh"

module lease_cache_tb;

	localparam logic [31:0] ENABLE = 32'h1 << `COMM_ENABLE_BIT;

	logic							clock_i = 1'b0;
	logic							resetn_i;
	logic							req_i;
	logic [31:0]					addr_i;
	lease_cache_pkg::access_kind_e	kind_i;
	logic [`LEASE_W-1:0]			lease_i;
	logic [31:0]					comm_i;
	logic [31:0]					comm_o;

	int	fall_count		= 0;		// falling edges so far
	int	test_errors		= 0;
	int	tests_passed	= 0;
	int	tests_failed	= 0;

	`include "lease_cache_model.svh"

	lease_cache_top lease_cache_top_inst (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.req_i		(req_i),
		.addr_i		(addr_i),
		.kind_i		(kind_i),
		.lease_i	(lease_i),
		.comm_i		(comm_i),
		.comm_o		(comm_o)
	);

	always begin
		#5 clock_i = 1'b1;
		#5;
		fall_count = fall_count + 1;	// updated before waiters wake
		clock_i = 1'b0;
	end

	// helpers
	// ----------------------------------------
	task automatic wait_falls(input int n);
		int target;
		int edges;
		target = fall_count + n;
		edges = 0;
		while (fall_count < target && edges < 2 * n + 2) begin
			@(clock_i);
			edges++;
		end
		if (fall_count < target) begin
			$display("Timeout: clock stopped before %0d falling edges arrived", n);
			$display("Verification failed");
			$finish;
		end
	endtask

	// set inputs at a falling edge, mirror them in the model, move to the next one
	task automatic drive_cycle(input logic req, input logic [31:0] addr, input logic is_write,
			input logic [`LEASE_W-1:0] lease, input logic [31:0] comm);
		req_i = req;
		addr_i = addr;
		kind_i = lease_cache_pkg::access_kind_e'(is_write);
		lease_i = lease;
		comm_i = comm;
		model_cycle(req, addr, is_write, lease, comm[`COMM_ENABLE_BIT]);
		wait_falls(1);
	endtask

	task automatic read_expect(input logic [31:0] comm);
		logic [31:0] expected;
		expected = model_readback(comm);
		drive_cycle(1'b0, 32'd0, 1'b0, '0, comm);		// comm_o registered one edge later
		if (comm_o !== expected) begin
			$display("Error at %0t: comm_o select %0d expected %08h, actual %08h",
				$time, comm[3:0], expected, comm_o);
			test_errors++;
		end
	endtask

	task automatic random_request(input logic [31:0] comm);
		logic [1:0]				pick;
		logic [TAG_W-1:0]		tag;
		logic [31:0]			addr;
		logic					is_write;
		logic [`LEASE_W-1:0]	lease;
		pick = 2'(rand_bits(2));
		case (pick)
			2'd0:		tag = TAG_W'(24'h00_0a51);
			2'd1:		tag = TAG_W'(24'h3c_0007);
			default:	tag = TAG_W'(24'hf1_2200);		// three tags force conflicts
		endcase
		addr = {tag, 8'(rand_bits(8))};
		is_write = rand_bits(1) != 0;
		if (rand_bits(2) == 0)
			lease = '0;				// about a quarter use the default
		else
			lease = `LEASE_W'(1 + rand_bits(3));
		drive_cycle(1'b1, addr, is_write, lease, comm);
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// test sequence
	// ----------------------------------------
	initial begin
		logic [31:0]	dut_before;
		logic [63:0]	model_before;
		logic [3:0]		idx;
		resetn_i = 1'b0;
		req_i = 1'b0;
		addr_i = '0;
		kind_i = lease_cache_pkg::ACCESS_READ;
		lease_i = '0;
		comm_i = '0;
		model_reset();
		wait_falls(3);				// three reset edges
		resetn_i = 1'b1;

		for (int s = 0; s < 14; s++)
			read_expect(32'(s));
		read_expect(32'd15);
		finish_test("reset readback");

		for (int n = 0; n < 50; n++)
			random_request(32'd0);
		drive_cycle(1'b0, 32'd0, 1'b0, '0, 32'd0);
		drive_cycle(1'b0, 32'd0, 1'b0, '0, 32'd0);
		for (int s = 0; s < 14; s++)
			read_expect(32'(s));
		finish_test("disabled counting");

		for (int n = 0; n < 400; n++)
			random_request(ENABLE);
		drive_cycle(1'b0, 32'd0, 1'b0, '0, ENABLE);		// last pulses land here
		drive_cycle(1'b0, 32'd0, 1'b0, '0, ENABLE);
		for (int s = 0; s < 14; s++)
			if (s != 6 && s != 7)
				read_expect(32'(s));
		finish_test("random event counts");

		read_expect(32'd6);
		read_expect(32'd7);
		if (comm_o !== 32'd0) begin
			$display("Error at %0t: comm_o wall time high word expected %08h, actual %08h",
				$time, 32'd0, comm_o);
			test_errors++;
		end
		finish_test("wall time");

		read_expect(32'd4);
		dut_before = comm_o;
		model_before = m_count[EV_WB];
		for (int p = 0; p < 20; p++) begin
			idx = 4'(rand_bits(4));
			drive_cycle(1'b1, {TAG_W'(24'h00_0a51), idx, 4'h0}, 1'b1, 8'd4, ENABLE);
			drive_cycle(1'b1, {TAG_W'(24'h3c_0007), idx, 4'h8}, 1'b0, 8'd4, ENABLE);
		end
		drive_cycle(1'b0, 32'd0, 1'b0, '0, ENABLE);
		drive_cycle(1'b0, 32'd0, 1'b0, '0, ENABLE);
		read_expect(32'd4);
		if (comm_o - dut_before != 32'(m_count[EV_WB] - model_before)) begin
			$display("Error at %0t: writeback delta expected %0d, actual %0d",
				$time, m_count[EV_WB] - model_before, comm_o - dut_before);
			test_errors++;
		end
		read_expect(32'd5);
		finish_test("dirty evictions");

		read_expect(32'd14);
		read_expect(32'h00e0_5a0e);		// select 14 with unrelated upper bits
		finish_test("unlisted selects");

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: hw/lease_cache_top.sv
`timescale 1ns/1ps

`include "lease_cache_config.svh"

module lease_cache_top (
	input	logic								clock_i,
	input	logic								resetn_i,
	input	logic								req_i,		// access strobe, one per cycle
	input	logic [31:0]						addr_i,
	input	lease_cache_pkg::access_kind_e		kind_i,
	input	logic [`LEASE_W-1:0]				lease_i,
	input	logic [31:0]						comm_i,		// configuration word
	output	logic [31:0]						comm_o		// selected counter half or id
);

	// event pulses, registered in the tag store
	// ----------------------------------------
	cache_event_if events_if ();

	// tag, dirty and lease arrays
	lease_tag_store tag_store_inst (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.req_i		(req_i),
		.addr_i		(addr_i),
		.kind_i		(kind_i),
		.lease_i	(lease_i),
		.events_o	(events_if.source)
	);

	// counters and readback
	cache_performance_controller perf_ctrl_inst (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.events_i	(events_if.sink),
		.comm_i		(comm_i),
		.comm_o		(comm_o)
	);

endmodule

// File: hw/cache_performance_controller.sv
`timescale 1ns/1ps

`include "lease_cache_config.svh"

module cache_performance_controller (
	input	logic			clock_i,
	input	logic			resetn_i,
	cache_event_if.sink		events_i,
	input	logic [31:0]	comm_i,		// bit 24 enables counting, bits 3:0 select readback
	output	logic [31:0]	comm_o
);

	// event counters
	// ----------------------------------------
	logic			count_en;
	logic [63:0]	hit_cnt_q;
	logic [63:0]	miss_cnt_q;
	logic [63:0]	wb_cnt_q;
	logic [63:0]	wall_cnt_q;			// enabled cycles
	logic [63:0]	expired_cnt_q;
	logic [63:0]	defaulted_cnt_q;
	logic [63:0]	mexpired_cnt_q;

	assign count_en = comm_i[`COMM_ENABLE_BIT];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			hit_cnt_q		<= '0;
			miss_cnt_q		<= '0;
			wb_cnt_q		<= '0;
			wall_cnt_q		<= '0;
			expired_cnt_q	<= '0;
			defaulted_cnt_q	<= '0;
			mexpired_cnt_q	<= '0;
		end else if (count_en) begin
			if (events_i.hit)			hit_cnt_q		<= hit_cnt_q + 64'd1;
			if (events_i.miss)			miss_cnt_q		<= miss_cnt_q + 64'd1;
			if (events_i.writeback)		wb_cnt_q		<= wb_cnt_q + 64'd1;
			if (events_i.expired)		expired_cnt_q	<= expired_cnt_q + 64'd1;
			if (events_i.defaulted)		defaulted_cnt_q	<= defaulted_cnt_q + 64'd1;
			if (events_i.expired_multi)	mexpired_cnt_q	<= mexpired_cnt_q + 64'd1;
			wall_cnt_q <= wall_cnt_q + 64'd1;		// every enabled edge
		end
	end

	// readback
	// ----------------------------------------
	lease_cache_pkg::perf_sel_e	sel;
	logic [31:0]				comm_q;

	assign sel = lease_cache_pkg::perf_sel_e'(comm_i[3:0]);

	// counters are read before this edge's update
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			comm_q <= '0;
		end else begin
			case (sel)
				lease_cache_pkg::SEL_HIT_LO:		comm_q <= hit_cnt_q[31:0];
				lease_cache_pkg::SEL_HIT_HI:		comm_q <= hit_cnt_q[63:32];
				lease_cache_pkg::SEL_MISS_LO:		comm_q <= miss_cnt_q[31:0];
				lease_cache_pkg::SEL_MISS_HI:		comm_q <= miss_cnt_q[63:32];
				lease_cache_pkg::SEL_WB_LO:			comm_q <= wb_cnt_q[31:0];
				lease_cache_pkg::SEL_WB_HI:			comm_q <= wb_cnt_q[63:32];
				lease_cache_pkg::SEL_WALL_LO:		comm_q <= wall_cnt_q[31:0];
				lease_cache_pkg::SEL_WALL_HI:		comm_q <= wall_cnt_q[63:32];
				lease_cache_pkg::SEL_EXPIRED_LO:	comm_q <= expired_cnt_q[31:0];
				lease_cache_pkg::SEL_EXPIRED_HI:	comm_q <= expired_cnt_q[63:32];
				lease_cache_pkg::SEL_DEFAULTED_LO:	comm_q <= defaulted_cnt_q[31:0];
				lease_cache_pkg::SEL_DEFAULTED_HI:	comm_q <= defaulted_cnt_q[63:32];
				lease_cache_pkg::SEL_MEXPIRED_LO:	comm_q <= mexpired_cnt_q[31:0];
				lease_cache_pkg::SEL_MEXPIRED_HI:	comm_q <= mexpired_cnt_q[63:32];
				lease_cache_pkg::SEL_CACHE_ID:
					comm_q <= `CACHE_ID_STRUCTURE | `CACHE_ID_REPLACEMENT;
				default:							comm_q <= '0;	// 14 and unlisted codes
			endcase
		end
	end

	assign comm_o = comm_q;

	// multi-expiry is a refinement of an expired eviction from the tag store
	mexpired_needs_expired_a: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		events_i.expired_multi |-> events_i.expired
	);

endmodule

// File: hw/lease_tag_store.sv
`timescale 1ns/1ps

`include "lease_cache_config.svh"

module lease_tag_store (
	input	logic								clock_i,
	input	logic								resetn_i,
	input	logic								req_i,		// one access this cycle
	input	logic [31:0]						addr_i,
	input	lease_cache_pkg::access_kind_e		kind_i,
	input	logic [`LEASE_W-1:0]				lease_i,	// zero selects the default lease
	cache_event_if.source						events_o
);

	localparam int LINES	= `LEASE_CACHE_LINES;
	localparam int INDEX_W	= `LEASE_CACHE_INDEX_W;
	localparam int OFFSET_W	= `LEASE_CACHE_OFFSET_W;
	localparam int LEASE_W	= `LEASE_W;
	localparam int TAG_W	= 32 - INDEX_W - OFFSET_W;	// upper address bits

	// line state
	// ----------------------------------------
	logic [LINES-1:0]		valid_q;				// line holds a tag
	logic [LINES-1:0]		dirty_q;				// line written since fill
	logic [TAG_W-1:0]		tag_q	[LINES];
	logic [LEASE_W-1:0]		lease_q	[LINES];		// remaining accesses before expiry

	// request decode
	// ----------------------------------------
	logic [INDEX_W-1:0]		req_index;
	logic [TAG_W-1:0]		req_tag;
	logic					is_write;
	logic					lease_zero;				// request asks for the default lease
	logic [LEASE_W-1:0]		fill_lease;				// lease loaded into the accessed line

	assign req_index	= addr_i[OFFSET_W +: INDEX_W];
	assign req_tag		= addr_i[31 -: TAG_W];
	assign is_write		= (kind_i == lease_cache_pkg::ACCESS_WRITE);
	assign lease_zero	= (lease_i == '0);
	assign fill_lease	= lease_zero ? LEASE_W'(`LEASE_DEFAULT) : lease_i;

	// classification, all on pre-access state
	// ----------------------------------------
	logic					line_hit;
	logic					victim_dirty;			// writeback needed on a miss
	logic [LINES-1:0]		zero_flags;				// valid lines with an exhausted lease
	logic [LINES-1:0]		index_onehot;
	logic					victim_expired;
	logic					other_expired;			// some other line is expired as well

	assign line_hit		= valid_q[req_index] && (tag_q[req_index] == req_tag);
	assign victim_dirty	= valid_q[req_index] && dirty_q[req_index];

	always_comb begin
		for (int i = 0; i < LINES; i++) begin
			zero_flags[i] = valid_q[i] && (lease_q[i] == '0);
		end
	end

	assign index_onehot		= LINES'(1) << req_index;
	assign victim_expired	= zero_flags[req_index];
	assign other_expired	= |(zero_flags & ~index_onehot);	// reduction excludes the victim

	// registered event pulses
	// ----------------------------------------
	logic	hit_q;
	logic	miss_q;
	logic	writeback_q;
	logic	expired_q;
	logic	expired_multi_q;
	logic	defaulted_q;

	// control state: valid, dirty and the event pulses
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q			<= '0;		// every line invalid
			dirty_q			<= '0;
			hit_q			<= 1'b0;
			miss_q			<= 1'b0;
			writeback_q		<= 1'b0;
			expired_q		<= 1'b0;
			expired_multi_q	<= 1'b0;
			defaulted_q		<= 1'b0;
		end else begin
			hit_q			<= req_i && line_hit;
			miss_q			<= req_i && !line_hit;
			writeback_q		<= req_i && !line_hit && victim_dirty;
			expired_q		<= req_i && !line_hit && victim_expired;
			expired_multi_q	<= req_i && !line_hit && victim_expired && other_expired;
			defaulted_q		<= req_i && lease_zero;		// hit or miss

			if (req_i) begin
				valid_q[req_index] <= 1'b1;				// a miss fills at once
				if (!line_hit)
					dirty_q[req_index] <= is_write;		// fresh line, dirty only on write
				else if (is_write)
					dirty_q[req_index] <= 1'b1;
			end
		end
	end

	// tags and leases, qualified by valid_q
	always_ff @(posedge clock_i) begin
		if (req_i) begin
			for (int i = 0; i < LINES; i++) begin
				if (INDEX_W'(i) == req_index) begin
					lease_q[i] <= fill_lease;				// renew on hit and on fill
					if (!line_hit)
						tag_q[i] <= req_tag;
				end else if (valid_q[i] && (lease_q[i] != '0)) begin
					lease_q[i] <= lease_q[i] - 1'b1;		// countdown saturates at zero
				end
			end
		end
	end

	assign events_o.hit				= hit_q;
	assign events_o.miss			= miss_q;
	assign events_o.writeback		= writeback_q;
	assign events_o.expired			= expired_q;
	assign events_o.expired_multi	= expired_multi_q;
	assign events_o.defaulted		= defaulted_q;

	// checks on the outgoing pulses
	// ----------------------------------------
	// eviction side effects belong to a miss in the same cycle
	evict_needs_miss_a: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		(events_o.writeback || events_o.expired || events_o.expired_multi) |-> events_o.miss
	);

	// an access is classified exactly once
	hit_miss_exclusive_a: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		!(events_o.hit && events_o.miss)
	);

endmodule

// File: hw/cache_event_if.sv
`timescale 1ns/1ps

// one-cycle event pulses from the tag store to the counters
interface cache_event_if;

	logic	hit;			// access found a valid matching tag
	logic	miss;			// access replaced the line
	logic	writeback;		// victim was valid and dirty
	logic	expired;		// victim lease had run out
	logic	expired_multi;	// another valid line was expired too
	logic	defaulted;		// lease renewed with the default value

	modport source (
		output	hit, miss, writeback,
		output	expired, expired_multi, defaulted
	);

	modport sink (
		input	hit, miss, writeback,
		input	expired, expired_multi, defaulted
	);

endinterface

// File: hw/lease_cache_pkg.sv
package lease_cache_pkg;

	// readback selects on comm_i[3:0]
	// ----------------------------------------
	typedef enum logic [3:0] {
		SEL_HIT_LO			= 4'd0,		// hit counter
		SEL_HIT_HI			= 4'd1,
		SEL_MISS_LO			= 4'd2,		// miss counter
		SEL_MISS_HI			= 4'd3,
		SEL_WB_LO			= 4'd4,		// writeback counter
		SEL_WB_HI			= 4'd5,
		SEL_WALL_LO			= 4'd6,		// enabled cycles
		SEL_WALL_HI			= 4'd7,
		SEL_EXPIRED_LO		= 4'd8,		// expired lease replacements
		SEL_EXPIRED_HI		= 4'd9,
		SEL_DEFAULTED_LO	= 4'd10,	// renewals with the default lease
		SEL_DEFAULTED_HI	= 4'd11,
		SEL_MEXPIRED_LO		= 4'd12,	// several leases expired at eviction
		SEL_MEXPIRED_HI		= 4'd13,
		SEL_CACHE_ID		= 4'd15		// structure | replacement code
	} perf_sel_e;

	// request kind
	// ----------------------------------------
	typedef enum logic {
		ACCESS_READ		= 1'b0,
		ACCESS_WRITE	= 1'b1		// sets the dirty bit of the line
	} access_kind_e;

endpackage

// File: hw/lease_cache_config.svh
`ifndef LEASE_CACHE_CONFIG_SVH
`define LEASE_CACHE_CONFIG_SVH

// cache geometry
// ----------------------------------------
`define LEASE_CACHE_LINES		16		// direct-mapped lines, power of two
`define LEASE_CACHE_INDEX_W		4		// log2 of the line count
`define LEASE_CACHE_OFFSET_W	4		// block offset bits below the index

// lease counts
// ----------------------------------------
`define LEASE_W					8		// width of one lease counter
`define LEASE_DEFAULT			8		// renewal value when a request carries lease zero

// identification and configuration word
// ----------------------------------------
`define CACHE_ID_STRUCTURE		(32'h0001_0000)	// direct-mapped organisation
`define CACHE_ID_REPLACEMENT	(32'h0000_0010)	// lease-based replacement
`define COMM_ENABLE_BIT			24		// count enable inside comm_i

`endif
